// File: Bender.yml
package:
  name: register_manager

sources:
  # packages first, then the design from the leaves up
  - files:
      - design/rm_isa_pkg.sv
      - design/rm_bus_pkg.sv
      - design/reg_op_decode.sv
      - design/bus_sequencer.sv
      - design/operand_store.sv
      - design/register_manager.sv

  # bound checks and the testbench top
  - target: test
    files:
      - tests/register_manager_asserts.sv
      - tests/register_manager_tb.sv

// File: design/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  rm_isa_pkg::decoded_t dec,
  input  rm_bus_pkg::bus_rsp_t bus_rsp,
  output rm_bus_pkg::bus_req_t bus_req,
  output logic                 start,
  output logic                 complete,
  output rm_isa_pkg::data_t    rdata
);
  import rm_isa_pkg::*;

  // one command per cmd_valid high phase
  logic  armed;
  // request loaded, waiting for a free bus
  logic  issue;
  // request sent, waiting for its completion
  logic  pending;
  // kind of the outstanding request
  logic  rd_kind;
  addr_t req_addr;
  data_t req_wdata;
  logic  fire;
  logic  dn_kind;
  logic  match;

  // acceptance, never while a transfer is still in flight
  assign start = cmd_valid && armed && !issue && !pending;

  // strobe goes out only in a cycle where the bus is free
  assign fire = issue && !bus_rsp.busy;

  always_comb begin
    bus_req.read  = fire && rd_kind;
    bus_req.write = fire && !rd_kind;
    bus_req.addr  = req_addr;
    bus_req.wdata = req_wdata;
  end

  // completion must be of the same kind
  assign dn_kind = rd_kind ? bus_rsp.read_dn : bus_rsp.write_dn;

  // echoed address must equal ours
  // other completions are someone else's, keep waiting
  assign match = pending && dn_kind && (bus_rsp.addr == req_addr);

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      armed    <= 1'b0;
      issue    <= 1'b0;
      pending  <= 1'b0;
      complete <= 1'b0;
    end else begin
      complete <= match;
      if (start) begin
        armed <= 1'b0;
        // catches finish without the bus
        issue <= dec.is_read || dec.is_write;
      end else if (!cmd_valid) begin
        // re-arm once the host has let go
        armed <= 1'b1;
      end
      if (fire) begin
        issue   <= 1'b0;
        pending <= 1'b1;
      end
      if (match) begin
        pending <= 1'b0;
      end
    end
  end

  // request payload latched at acceptance
  always_ff @(posedge clk) begin
    if (start) begin
      req_addr  <= dec.addr;
      req_wdata <= dec.wdata;
      rd_kind   <= dec.is_read;
    end
    // read data travels with complete
    if (match) begin
      rdata <= bus_rsp.rdata;
    end
  end

endmodule

// File: design/operand_store.sv
`timescale 1ns/1ps

module operand_store (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 complete,
  input  rm_isa_pkg::decoded_t dec,
  input  rm_isa_pkg::data_t    alu_result,
  input  rm_isa_pkg::data_t    ptr_in,
  input  rm_isa_pkg::data_t    rdata,
  output rm_isa_pkg::data_t    value,
  output rm_isa_pkg::data_t    ptr,
  output logic                 done
);

  logic catch_now;
  logic read_now;

  // catch needs no bus, takes effect on acceptance
  assign catch_now = start && dec.is_catch;

  // fetched word lands when the sequencer reports completion
  assign read_now = complete && dec.is_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
      ptr   <= '0;
      done  <= 1'b0;
    end else begin
      // every command ends with one done pulse
      // stores finish on complete too
      done <= catch_now || complete;
      if (catch_now) begin
        // pointer catch fills both words
        if (dec.catch_ptr) begin
          value <= ptr_in;
          ptr   <= ptr_in;
        end else begin
          value <= alu_result;
        end
      end else if (read_now) begin
        value <= rdata;
        // direct fetch also refreshes the pointer
        if (dec.load_ptr) begin
          ptr <= rdata;
        end
      end
    end
  end

endmodule

// File: design/reg_op_decode.sv
`timescale 1ns/1ps

module reg_op_decode (
  input  rm_isa_pkg::reg_cmd_t cmd,
  input  rm_isa_pkg::data_t    value,
  input  rm_isa_pkg::data_t    ptr,
  output rm_isa_pkg::decoded_t dec,
  output rm_isa_pkg::data_t    ptr_out
);
  import rm_isa_pkg::*;

  addr_t reg_addr;
  addr_t ptr_addr;
  logic  store_value;
  data_t store_word;
  data_t modified;

  // register slot sits at base plus register number
  assign reg_addr = cmd.desc.base_addr + addr_t'(cmd.desc.reg_num);
  // indirect access is relative to the same base
  assign ptr_addr = cmd.desc.base_addr + addr_t'(ptr);

  // plain register store or pointer-mode store through pointer
  // both put the value on the bus
  assign store_value = (!cmd.desc.is_ptr && cmd.op == op_write) ||
                       (cmd.desc.is_ptr && cmd.op == op_write_p);

  // everything else moves the pointer word
  assign store_word = store_value ? value : ptr;

  // post-modify only on register store
  always_comb begin
    modified = store_word;
    if (cmd.op == op_write) begin
      case (cmd.desc.step)
        step_inc: modified = store_word + data_t'(1);
        step_dec: modified = store_word - data_t'(1);
        default:  modified = store_word;
      endcase
    end
  end

  // opcode classification
  always_comb begin
    dec       = '0;
    dec.addr  = reg_addr;
    dec.wdata = modified;
    case (cmd.op)
      op_catch_value: begin
        dec.is_catch = 1'b1;
      end
      op_catch_ptr: begin
        dec.is_catch  = 1'b1;
        dec.catch_ptr = 1'b1;
      end
      op_read: begin
        dec.is_read  = 1'b1;
        dec.load_ptr = 1'b1;
      end
      op_read_p: begin
        // pointer stays, only value is refreshed
        dec.is_read = 1'b1;
        dec.addr    = ptr_addr;
      end
      op_write: begin
        dec.is_write = 1'b1;
      end
      op_write_p: begin
        dec.is_write = 1'b1;
        dec.addr     = ptr_addr;
      end
      default: begin
        // spare encodings stay idle
      end
    endcase
  end

  // pointer as seen after the store step
  assign ptr_out = modified;

endmodule

// File: design/register_manager.sv
`timescale 1ns/1ps

module register_manager (
  input  logic                 clk,
  input  logic                 rst,
  input  rm_isa_pkg::reg_cmd_t cmd,
  input  logic                 cmd_valid,
  input  rm_isa_pkg::data_t    alu_result,
  input  rm_isa_pkg::data_t    ptr_in,
  input  rm_bus_pkg::bus_rsp_t bus_rsp,
  output rm_bus_pkg::bus_req_t bus_req,
  output rm_isa_pkg::data_t    value,
  output rm_isa_pkg::data_t    ptr_out,
  output logic                 done
);
  import rm_isa_pkg::*;

  // decoded view of the held command
  decoded_t dec;
  // held pointer, before post-modify
  data_t    ptr;
  logic     start;
  logic     complete;
  data_t    rdata;

  // address, store word and step arithmetic
  reg_op_decode reg_op_decode_i (
    .cmd     (cmd),
    .value   (value),
    .ptr     (ptr),
    .dec     (dec),
    .ptr_out (ptr_out)
  );

  // acceptance and bus handshake
  bus_sequencer bus_sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .dec       (dec),
    .bus_rsp   (bus_rsp),
    .bus_req   (bus_req),
    .start     (start),
    .complete  (complete),
    .rdata     (rdata)
  );

  // value and pointer registers, done pulse
  operand_store operand_store_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .complete   (complete),
    .dec        (dec),
    .alu_result (alu_result),
    .ptr_in     (ptr_in),
    .rdata      (rdata),
    .value      (value),
    .ptr        (ptr),
    .done       (done)
  );

endmodule

// File: design/rm_bus_pkg.sv
package rm_bus_pkg;

  // request side, read and write are single-cycle strobes
  typedef struct packed {
    logic              read;
    logic              write;
    rm_isa_pkg::addr_t addr;
    rm_isa_pkg::data_t wdata;
  } bus_req_t;

  // response side
  // busy covers the whole transfer
  // the done strobes carry the echoed address
  typedef struct packed {
    logic              busy;
    logic              read_dn;
    logic              write_dn;
    rm_isa_pkg::addr_t addr;
    rm_isa_pkg::data_t rdata;
  } bus_rsp_t;

endpackage

// File: design/rm_isa_pkg.sv
package rm_isa_pkg;

  // architectural widths
  localparam int data_w    = 32;
  localparam int addr_w    = 32;
  localparam int reg_num_w = 4;

  typedef logic [data_w-1:0] data_t;
  typedef logic [addr_w-1:0] addr_t;

  // operand command opcodes
  typedef enum logic [2:0] {
    op_catch_value = 3'd0,  // value from alu result
    op_catch_ptr   = 3'd1,  // value and pointer from ptr_in
    op_read        = 3'd2,  // fetch register slot
    op_read_p      = 3'd3,  // fetch through held pointer
    op_write       = 3'd4,  // store register slot
    op_write_p     = 3'd5   // store through held pointer
  } reg_op_e;

  // post-modify on store
  typedef enum logic [1:0] {
    step_none = 2'b00,
    step_inc  = 2'b01,
    step_dec  = 2'b10
  } step_e;

  // how the operand is addressed
  typedef struct packed {
    logic                 is_ptr;
    step_e                step;
    logic [reg_num_w-1:0] reg_num;
    addr_t                base_addr;  // per-process register window
  } operand_desc_t;

  typedef struct packed {
    reg_op_e       op;
    operand_desc_t desc;
  } reg_cmd_t;

  // control and data derived from the held command
  typedef struct packed {
    logic  is_catch;
    logic  catch_ptr;  // catch also loads the pointer
    logic  is_read;
    logic  is_write;
    logic  load_ptr;   // read data goes to the pointer too
    addr_t addr;
    data_t wdata;
  } decoded_t;

endpackage

// File: src.f
design/rm_isa_pkg.sv
design/rm_bus_pkg.sv
design/reg_op_decode.sv
design/bus_sequencer.sv
design/operand_store.sv
design/register_manager.sv
tests/register_manager_asserts.sv
tests/register_manager_tb.sv

// File: tests/register_manager_asserts.sv
`timescale 1ns/1ps

module register_manager_asserts (
  input logic                 clk,
  input logic                 rst,
  input rm_bus_pkg::bus_req_t bus_req,
  input rm_bus_pkg::bus_rsp_t bus_rsp,
  input logic                 done
);

  logic req_any;

  // any strobe on the request side
  assign req_any = bus_req.read || bus_req.write;

  // one direction per request
  one_kind_a: assert property (@(posedge clk) disable iff (rst)
    !(bus_req.read && bus_req.write))
    else $error("read and write strobed in the same cycle");

  // done is a single-cycle pulse
  done_pulse_a: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else $error("done held high for two cycles");

  // memory must be free when a request goes out
  free_bus_a: assert property (@(posedge clk) disable iff (rst)
    req_any |-> !bus_rsp.busy)
    else $error("request strobed while busy was high");

  // nothing leaves the unit right out of reset
  quiet_reset_a: assert property (@(posedge clk)
    rst |=> !(req_any || done))
    else $error("request or done in the cycle after reset");

endmodule

bind register_manager register_manager_asserts register_manager_asserts_i (
  .clk     (clk),
  .rst     (rst),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp),
  .done    (done)
);

// File: tests/register_manager_tb.sv
`timescale 1ns/1ps

module register_manager_tb;
  import rm_isa_pkg::*;
  import rm_bus_pkg::*;

  localparam int clk_period  = 4;
  localparam int num_tests   = 6;
  // watchdog budget per test in cycles
  localparam int test_cycles = 200;
  // longest wait for one done
  localparam int done_limit  = 64;

  logic     clk;
  logic     rst;
  reg_cmd_t cmd;
  logic     cmd_valid;
  data_t    alu_result;
  data_t    ptr_in;
  bus_rsp_t bus_rsp;
  bus_req_t bus_req;
  data_t    value;
  data_t    ptr_out;
  logic     done;

  // memory model outputs
  logic  mem_busy;
  // extra busy from the tests for back-pressure
  logic  stall;
  logic  rsp_read_dn;
  logic  rsp_write_dn;
  addr_t rsp_addr;
  data_t rsp_rdata;
  data_t mem [256];

  // expected state of the unit and memory
  data_t ref_value;
  data_t ref_ptr;
  data_t ref_mem [256];

  bus_req_t last_req;
  int       req_count;
  int       cmp_count;
  // negedge that drove the last real completion
  time      cmp_time;
  int       seed;
  int       errors;
  int       test_errors;
  int       checks;

  always_comb begin
    bus_rsp.busy     = mem_busy || stall;
    bus_rsp.read_dn  = rsp_read_dn;
    bus_rsp.write_dn = rsp_write_dn;
    bus_rsp.addr     = rsp_addr;
    bus_rsp.rdata    = rsp_rdata;
  end

  register_manager register_manager_i (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .alu_result (alu_result),
    .ptr_in     (ptr_in),
    .bus_rsp    (bus_rsp),
    .bus_req    (bus_req),
    .value      (value),
    .ptr_out    (ptr_out),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // start contents give every address its own word
  function automatic data_t fill_word(input int a);
    return (a * 32'h0101_0101) ^ 32'h5a00_c300;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_req(input bus_req_t got, input bus_req_t exp);
    logic wdata_bad;
    checks++;
    // store word only matters on writes
    wdata_bad = exp.write && (got.wdata !== exp.wdata);
    if (got.read !== exp.read || got.write !== exp.write || got.addr !== exp.addr ||
        wdata_bad) begin
      $display("FAILED bus_req: got 0x%h expected 0x%h", got, exp);
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished with %0d errors", name, test_errors);
    errors += test_errors;
    test_errors = 0;
  endtask

  // memory and reference side by side
  task automatic preload(input int idx, input data_t word);
    mem[idx]     = word;
    ref_mem[idx] = word;
  endtask

  // one command with expected results from the operand rules
  task automatic run_cmd(input reg_op_e op, input logic is_ptr, input step_e step,
                         input logic [reg_num_w-1:0] reg_num, input addr_t base,
                         input data_t alu, input data_t pin, input int stall_cycles);
    bus_req_t exp_req;
    logic     is_bus;
    logic     is_write;
    logic     store_val;
    logic     seen;
    data_t    word;
    addr_t    addr;
    int       rc0;
    int       cc0;
    int       n;
    int       hold;
    is_write  = (op == op_write) || (op == op_write_p);
    is_bus    = is_write || (op == op_read) || (op == op_read_p);
    // value goes out on a plain store or a pointer-mode store through pointer
    store_val = (!is_ptr && op == op_write) || (is_ptr && op == op_write_p);
    word      = store_val ? ref_value : ref_ptr;
    if (op == op_write && step == step_inc) word = word + 1;
    if (op == op_write && step == step_dec) word = word - 1;
    addr = (op == op_read_p || op == op_write_p) ? base + ref_ptr : base + addr_t'(reg_num);
    exp_req.read  = (op == op_read) || (op == op_read_p);
    exp_req.write = is_write;
    exp_req.addr  = addr;
    exp_req.wdata = word;
    @(negedge clk);
    rc0 = req_count;
    cc0 = cmp_count;
    cmd.op             = op;
    cmd.desc.is_ptr    = is_ptr;
    cmd.desc.step      = step;
    cmd.desc.reg_num   = reg_num;
    cmd.desc.base_addr = base;
    alu_result = alu;
    ptr_in     = pin;
    cmd_valid  = 1'b1;
    hold  = stall_cycles;
    stall = hold > 0;
    n     = 0;
    seen  = 1'b0;
    while (!seen && n < done_limit) begin
      @(negedge clk);
      n++;
      if (hold > 0) hold--;
      stall = hold > 0;
      seen  = done;
    end
    stall = 1'b0;
    if (!seen) begin
      note_failure($sformatf("no done within %0d cycles for %s", done_limit, op.name()));
    end else begin
      case (op)
        op_catch_value: ref_value = alu;
        op_catch_ptr: begin
          ref_value = pin;
          ref_ptr   = pin;
        end
        op_read: begin
          ref_value = ref_mem[addr[7:0]];
          ref_ptr   = ref_value;
        end
        op_read_p: ref_value = ref_mem[addr[7:0]];
        default: ref_mem[addr[7:0]] = word;
      endcase
      check_data("value", value, ref_value);
      // cmd still held, so ptr_out shows the post-modify word
      check_data("ptr_out", ptr_out, is_write ? word : ref_ptr);
      if (is_bus) begin
        if (req_count != rc0 + 1) begin
          note_failure($sformatf("%s issued %0d bus requests", op.name(), req_count - rc0));
        end
        check_req(last_req, exp_req);
        if (cmp_count != cc0 + 1) begin
          note_failure($sformatf("%s done came without its matching completion", op.name()));
        end
        // done rises on the edge after the one that samples the real completion
        if ($time != cmp_time + 2 * clk_period) begin
          note_failure($sformatf("%s done not one cycle after its matching completion",
                                 op.name()));
        end
      end else begin
        if (n != 1) note_failure($sformatf("catch done after %0d cycles instead of 1", n));
        if (req_count != rc0) note_failure("catch command went out on the bus");
      end
    end
    // let go so the unit re-arms on the low level
    cmd_valid = 1'b0;
  endtask

  // answers one request at a time after a random delay, maybe with a decoy first
  initial begin
    bus_req_t req;
    int       delay;
    int       idx;
    mem_busy     = 1'b0;
    rsp_read_dn  = 1'b0;
    rsp_write_dn = 1'b0;
    rsp_addr     = '0;
    rsp_rdata    = '0;
    forever begin
      @(posedge clk);
      if (!rst && (bus_req.read || bus_req.write)) begin
        req      = bus_req;
        last_req = req;
        req_count++;
        @(negedge clk);
        mem_busy = 1'b1;
        delay    = 1 + ($unsigned($random(seed)) % 6);
        repeat (delay - 1) @(negedge clk);
        if ($random(seed) & 1) begin
          // same kind with a wrong address
          rsp_read_dn  = req.read;
          rsp_write_dn = req.write;
          rsp_addr     = req.addr ^ 32'h0000_0101;
          rsp_rdata    = 32'hbad0_bad0;
          @(negedge clk);
          rsp_read_dn  = 1'b0;
          rsp_write_dn = 1'b0;
        end
        idx = req.addr[7:0];
        if (req.write) mem[idx] = req.wdata;
        rsp_read_dn  = req.read;
        rsp_write_dn = req.write;
        rsp_addr     = req.addr;
        rsp_rdata    = mem[idx];
        cmp_count++;
        cmp_time = $time;
        @(negedge clk);
        rsp_read_dn  = 1'b0;
        rsp_write_dn = 1'b0;
        rsp_addr     = '0;
        rsp_rdata    = '0;
        mem_busy     = 1'b0;
      end
    end
  end

  task automatic test_reset();
    int i;
    check_data("value", value, '0);
    check_data("ptr_out", ptr_out, '0);
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      if (done) note_failure("done pulsed with no command");
    end
    if (req_count != 0) note_failure("bus request issued with no command");
    finish_test("reset");
  endtask

  task automatic test_catch_store();
    run_cmd(op_catch_value, 1'b0, step_none, 4'd0, 32'h0, 32'hcafe_0123, 32'h0, 0);
    run_cmd(op_write, 1'b0, step_none, 4'd5, 32'h20, 32'h0, 32'h0, 0);
    check_data("mem[0x25]", mem[8'h25], 32'hcafe_0123);
    check_data("value", value, 32'hcafe_0123);
    finish_test("catch_store");
  endtask

  task automatic test_fetch();
    preload(8'h33, 32'h0000_0010);
    preload(8'h40, 32'h1234_5678);
    run_cmd(op_read, 1'b0, step_none, 4'd3, 32'h30, 32'h0, 32'h0, 0);
    check_data("value", value, 32'h0000_0010);
    check_data("ptr_out", ptr_out, 32'h0000_0010);
    // 0x30 plus the fetched pointer
    run_cmd(op_read_p, 1'b0, step_none, 4'd0, 32'h30, 32'h0, 32'h0, 0);
    check_data("value", value, 32'h1234_5678);
    check_data("ptr_out", ptr_out, 32'h0000_0010);
    finish_test("fetch");
  endtask

  task automatic test_post_modify();
    run_cmd(op_catch_ptr, 1'b0, step_none, 4'd0, 32'h0, 32'h0, 32'h0000_0080, 0);
    run_cmd(op_write, 1'b1, step_inc, 4'd2, 32'h50, 32'h0, 32'h0, 0);
    check_data("mem[0x52]", mem[8'h52], 32'h0000_0081);
    check_data("ptr_out", ptr_out, 32'h0000_0081);
    // held pointer is still 0x80
    run_cmd(op_write, 1'b1, step_dec, 4'd3, 32'h50, 32'h0, 32'h0, 0);
    check_data("mem[0x53]", mem[8'h53], 32'h0000_007f);
    check_data("ptr_out", ptr_out, 32'h0000_007f);
    finish_test("post_modify");
  endtask

  task automatic test_store_ptr();
    run_cmd(op_catch_ptr, 1'b0, step_none, 4'd0, 32'h0, 32'h0, 32'h0000_0011, 0);
    run_cmd(op_catch_value, 1'b0, step_none, 4'd0, 32'h0, 32'hdead_beef, 32'h0, 0);
    // step inc is ignored here
    run_cmd(op_write_p, 1'b1, step_inc, 4'd0, 32'h60, 32'h0, 32'h0, 0);
    check_data("mem[0x71]", mem[8'h71], 32'hdead_beef);
    check_data("ptr_out", ptr_out, 32'hdead_beef);
    finish_test("store_ptr");
  endtask

  task automatic test_random();
    reg_op_e op;
    step_e   step;
    logic    is_ptr;
    int      k;
    int      i;
    for (k = 0; k < 24; k++) begin
      op     = reg_op_e'($unsigned($random(seed)) % 6);
      step   = step_e'($unsigned($random(seed)) % 3);
      is_ptr = $random(seed) & 1;
      run_cmd(op, is_ptr, step, 4'($random(seed)), addr_t'($random(seed)),
              data_t'($random(seed)), data_t'($random(seed)), $unsigned($random(seed)) % 4);
    end
    for (i = 0; i < 256; i++) begin
      check_data($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
    finish_test("random");
  endtask

  initial begin
    int i;
    seed        = 74;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    req_count   = 0;
    cmp_count   = 0;
    cmp_time    = 0;
    rst         = 1'b1;
    cmd         = '0;
    cmd_valid   = 1'b0;
    alu_result  = '0;
    ptr_in      = '0;
    stall       = 1'b0;
    ref_value   = '0;
    ref_ptr     = '0;
    for (i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_catch_store();
    test_fetch();
    test_post_modify();
    test_store_ptr();
    test_random();
    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // hard stop if a handshake never finishes
  initial begin
    #(num_tests * test_cycles * clk_period);
    $display("watchdog expired after %0d cycles, run stopped", num_tests * test_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule
